/* rx_trace.txt */
// tag_lane3_lane2_lane1_lane0, tags: 1 idle bits in low field, 2 line codes per lane,
// 3 expected {k,err} digit and byte per lane, 4 hold ready low, 5 release ready, f end
1_000_000_000_040
2_0FA_0FA_0FA_0FA
2_305_305_305_305
2_274_1D9_2D5_31C
2_35D_29A_196_38E
2_155_2AA_259_0DC
2_1D9_274_31C_2D5
3_000_021_042_063
3_084_0A5_0C6_0E7
3_04A_0B5_029_06C
3_021_000_063_042
// Control symbols K28.0 and K23.7
1_000_000_000_03C
2_0FA_0FA_0FA_0FA
2_305_305_305_305
2_0F4_3A8_274_35D
2_3A8_0F4_1D9_155
2_274_274_274_274
2_2AA_29A_0F4_3A8
3_21C_2F7_000_084
3_2F7_21C_021_04A
3_000_000_000_000
3_0B5_0A5_21C_2F7
// Invalid codes on single lanes
1_000_000_000_03C
2_0FA_0FA_0FA_0FA
2_305_305_305_305
2_274_1D9_000_2D5
2_29F_1D9_2D5_31C
2_35D_29A_196_38E
2_155_2AA_259_000
3_000_021_100_042
3_105_021_042_063
3_084_0A5_0C6_0E7
3_04A_0B5_029_100
// One comma only
1_000_000_000_03C
2_0FA_0FA_0FA_0FA
2_274_1D9_2D5_31C
2_35D_29A_196_38E
2_155_2AA_259_0DC
2_1D9_274_31C_2D5
// Broken comma spacing
1_000_000_000_03C
2_0FA_0FA_0FA_0FA
1_000_000_000_003
2_305_305_305_305
2_274_1D9_2D5_31C
2_35D_29A_196_38E
2_155_2AA_259_0DC
2_1D9_274_31C_2D5
// Recovery frame
1_000_000_000_03C
2_0FA_0FA_0FA_0FA
2_305_305_305_305
2_35D_29A_196_38E
2_274_1D9_2D5_31C
2_1D9_274_31C_2D5
2_155_2AA_259_0DC
3_084_0A5_0C6_0E7
3_000_021_042_063
3_021_000_063_042
3_04A_0B5_029_06C
// Two frames with ready held low, only the first survives
1_000_000_000_03C
4_000_000_000_000
1_000_000_000_03C
2_0FA_0FA_0FA_0FA
2_305_305_305_305
2_155_2AA_259_0DC
2_35D_29A_196_38E
2_1D9_274_31C_2D5
2_274_1D9_2D5_31C
1_000_000_000_03C
2_0FA_0FA_0FA_0FA
2_305_305_305_305
2_274_1D9_2D5_31C
2_274_1D9_2D5_31C
2_274_1D9_2D5_31C
2_274_1D9_2D5_31C
1_000_000_000_014
5_000_000_000_000
3_04A_0B5_029_06C
3_084_0A5_0C6_0E7
3_021_000_063_042
3_000_021_042_063
1_000_000_000_064
f_000_000_000_000

/* rx_link.f */
+incdir+.
rx_pkg.sv
comma_align.sv
dec_8b10b.sv
rx_lane.sv
lane_merge.sv
rx_link.sv
tb_rx_link.sv

/* Bender.yml */
package:
  name: rx_link

export_include_dirs:
  - .

sources:
  - files:
      - rx_pkg.sv
      - comma_align.sv
      - dec_8b10b.sv
      - rx_lane.sv
      - lane_merge.sv
      - rx_link.sv
  - target: simulation
    files:
      - tb_rx_link.sv

/* tb_rx_link.sv */
`timescale 1ns/1ns
`include "rx_macros.svh"

module tb_rx_link;

  localparam int LANES     = `RX_LANES;
  localparam int REC_W     = 4 + 12 * LANES;
  localparam int TRACE_LEN = 128;

  logic               clk;
  logic               rst_n;
  logic [LANES-1:0]   serial_in;
  logic [8*LANES-1:0] word_data;
  logic [LANES-1:0]   word_k;
  logic [LANES-1:0]   word_err;
  logic               word_valid;
  logic               word_ready;
  logic               overflow;

  logic [REC_W-1:0]   trace [TRACE_LEN];
  logic [8*LANES-1:0] exp_data [$];
  logic [LANES-1:0]   exp_k [$];
  logic [LANES-1:0]   exp_err [$];
  logic               hold;
  logic [31:0]        lcg_state;
  int                 cycle_count;
  int                 cycle_limit;
  logic               prev_stall;
  logic [8*LANES+2*LANES-1:0] prev_word;

  rx_link #(
    .LANES (LANES)
  ) i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .serial_in  (serial_in),
    .word_data  (word_data),
    .word_k     (word_k),
    .word_err   (word_err),
    .word_valid (word_valid),
    .word_ready (word_ready),
    .overflow   (overflow)
  );

  always #10 clk = ~clk;

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("FAILED time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Idle filler is all zeros on every lane.
  task automatic send_idle(input int bits);
    repeat (bits) begin
      @(posedge clk);
      #2;
      serial_in = '0;
    end
  endtask

  // Shifts out one code per lane with the first code bit first.
  task automatic serialize_codes(input logic [REC_W-1:0] rec);
    for (int b = 9; b >= 0; b--) begin
      @(posedge clk);
      #2;
      for (int i = 0; i < LANES; i++) begin
        serial_in[i] = rec[12*i + b];
      end
    end
  endtask

  // Random ready throttle that holds ready low about one cycle in four.
  always @(posedge clk) begin
    #2;
    lcg_state  = lcg_next(lcg_state);
    word_ready = !hold && (lcg_state[20:19] != 2'b00);
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Timeout with %0d expected words still missing", exp_data.size());
      stop_on_error();
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      // A stalled word must hold.
      if (prev_stall) begin
        check("word_valid held", 1, word_valid);
        check("word held", prev_word, {word_data, word_k, word_err});
      end
      if (word_valid && word_ready) begin
        if (exp_data.size() == 0) begin
          $display("A word was delivered when no word was expected");
          stop_on_error();
        end
        check("word_data", exp_data.pop_front(), word_data);
        check("word_k", exp_k.pop_front(), word_k);
        check("word_err", exp_err.pop_front(), word_err);
      end
      prev_stall = word_valid && !word_ready;
      prev_word  = {word_data, word_k, word_err};
    end
  end

  initial begin
    logic [REC_W-1:0]   rec;
    logic [8*LANES-1:0] d;
    logic [LANES-1:0]   k;
    logic [LANES-1:0]   e;
    int                 total_bits;
    int                 idx;
    clk         = 1'b0;
    rst_n       = 1'b0;
    serial_in   = '0;
    word_ready  = 1'b0;
    hold        = 1'b0;
    lcg_state   = 32'd38620;
    cycle_count = 0;
    cycle_limit = 0;
    prev_stall  = 1'b0;
    prev_word   = '0;
    total_bits  = 0;

    $readmemh("rx_trace.txt", trace);
    idx = 0;
    while (trace[idx][REC_W-1 -: 4] !== 4'hf) begin
      rec = trace[idx];
      if ($isunknown(rec) || idx == TRACE_LEN - 1) begin
        $display("The trace file has no end record or holds a bad line");
        stop_on_error();
      end
      case (rec[REC_W-1 -: 4])
        4'h1: total_bits += int'(rec[15:0]);
        4'h2: total_bits += 10;
        4'h3: begin
          for (int i = 0; i < LANES; i++) begin
            d[8*i +: 8] = rec[12*i +: 8];
            k[i]        = rec[12*i + 9];
            e[i]        = rec[12*i + 8];
          end
          exp_data.push_back(d);
          exp_k.push_back(k);
          exp_err.push_back(e);
        end
        default: ;
      endcase
      idx++;
    end
    cycle_limit = total_bits + 200 + 10;

    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    idx = 0;
    while (trace[idx][REC_W-1 -: 4] != 4'hf) begin
      rec = trace[idx];
      case (rec[REC_W-1 -: 4])
        4'h1: send_idle(int'(rec[15:0]));
        4'h2: serialize_codes(rec);
        4'h4: begin
          check("overflow before hold", 0, overflow);
          hold = 1'b1;
        end
        4'h5: hold = 1'b0;
        default: ;
      endcase
      idx++;
    end

    while (exp_data.size() != 0) begin
      @(posedge clk);
    end
    repeat (50) @(posedge clk);
    check("overflow after hold", 1, overflow);
    $display("Test passed");
    $finish;
  end

endmodule

/* rx_link.sv */
`timescale 1ns/1ns
`include "rx_macros.svh"

module rx_link #(
  parameter int LANES = `RX_LANES
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [LANES-1:0]   serial_in,
  output logic [8*LANES-1:0] word_data,
  output logic [LANES-1:0]   word_k,
  output logic [LANES-1:0]   word_err,
  output logic               word_valid,
  input  logic               word_ready,
  output logic               overflow
);

  rx_pkg::sym_t [LANES-1:0] sym;
  logic [LANES-1:0]         sym_valid;

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    rx_lane i_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .serial_in (serial_in[i]),
      .sym       (sym[i]),
      .sym_valid (sym_valid[i])
    );
  end

  lane_merge #(
    .LANES (LANES)
  ) i_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .sym        (sym),
    .sym_valid  (sym_valid),
    .word_data  (word_data),
    .word_k     (word_k),
    .word_err   (word_err),
    .word_valid (word_valid),
    .word_ready (word_ready),
    .overflow   (overflow)
  );

endmodule

/* lane_merge.sv */
`timescale 1ns/1ns
`include "rx_macros.svh"

module lane_merge #(
  parameter int LANES = `RX_LANES
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  rx_pkg::sym_t [LANES-1:0] sym,
  input  logic [LANES-1:0]         sym_valid,
  output logic [8*LANES-1:0]       word_data,
  output logic [LANES-1:0]         word_k,
  output logic [LANES-1:0]         word_err,
  output logic                     word_valid,
  input  logic                     word_ready,
  output logic                     overflow
);

  localparam int DEPTH = `RX_QUEUE_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  rx_pkg::sym_t     mem [LANES][DEPTH];
  logic [AW:0]      wr_ptr [LANES];
  logic [AW:0]      wr_ptr_next [LANES];
  logic [AW:0]      rd_ptr;
  logic [AW:0]      rd_ptr_next;
  logic [LANES-1:0] full;
  logic [LANES-1:0] push;
  logic [LANES-1:0] filled_next;
  logic             pop;

  // All queues give up their head together.
  assign pop         = word_valid && word_ready;
  assign rd_ptr_next = rd_ptr + {{AW{1'b0}}, pop};

  for (genvar i = 0; i < LANES; i++) begin : g_queue
    assign full[i] = (wr_ptr[i][AW] != rd_ptr[AW]) &&
                     (wr_ptr[i][AW-1:0] == rd_ptr[AW-1:0]);
    assign push[i]        = sym_valid[i] && !full[i];
    assign wr_ptr_next[i] = wr_ptr[i] + {{AW{1'b0}}, push[i]};
    assign filled_next[i] = (wr_ptr_next[i] != rd_ptr_next);

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        wr_ptr[i] <= '0;
      end else begin
        wr_ptr[i] <= wr_ptr_next[i];
      end
    end

    always_ff @(posedge clk) begin
      if (push[i]) begin
        mem[i][wr_ptr[i][AW-1:0]] <= sym[i];
      end
    end

    assign word_data[8*i +: 8] = mem[i][rd_ptr[AW-1:0]].data;
    assign word_k[i]           = mem[i][rd_ptr[AW-1:0]].k;
    assign word_err[i]         = mem[i][rd_ptr[AW-1:0]].err;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr     <= '0;
      word_valid <= 1'b0;
      overflow   <= 1'b0;
    end else begin
      rd_ptr     <= rd_ptr_next;
      word_valid <= &filled_next;
      // A strobe into a full queue is lost.
      overflow   <= overflow || |(sym_valid & full);
    end
  end

endmodule

/* rx_lane.sv */
`timescale 1ns/1ns

module rx_lane (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         serial_in,
  output rx_pkg::sym_t sym,
  output logic         sym_valid
);

  rx_pkg::code_t code;
  logic          code_valid;

  // Framing.
  comma_align i_align (
    .clk        (clk),
    .rst_n      (rst_n),
    .serial_in  (serial_in),
    .code       (code),
    .code_valid (code_valid)
  );

  // Decode of each framed code.
  dec_8b10b i_dec (
    .clk        (clk),
    .rst_n      (rst_n),
    .code       (code),
    .code_valid (code_valid),
    .sym        (sym),
    .sym_valid  (sym_valid)
  );

endmodule

/* dec_8b10b.sv */
`timescale 1ns/1ns

module dec_8b10b (
  input  logic          clk,
  input  logic          rst_n,
  input  rx_pkg::code_t code,
  input  logic          code_valid,
  output rx_pkg::sym_t  sym,
  output logic          sym_valid
);

  logic [5:0] six;
  logic [3:0] four;
  logic [3:0] four_adj;
  logic [4:0] x;
  logic [2:0] y;
  logic       six_err;
  logic       four_err;
  logic       k28;
  logic       kx7;

  // abcdei in the upper six bits, fghj below.
  assign six  = code[9:4];
  assign four = code[3:0];

  assign k28 = (six == 6'b001111) || (six == 6'b110000);

  // Behind the positive K28 form the 4b sub-block reads complemented.
  assign four_adj = (six == 6'b110000) ? ~four : four;

  always_comb begin
    six_err = 1'b0;
    case (six)
      6'b100111, 6'b011000: x = 5'd0;
      6'b011101, 6'b100010: x = 5'd1;
      6'b101101, 6'b010010: x = 5'd2;
      6'b110001:            x = 5'd3;
      6'b110101, 6'b001010: x = 5'd4;
      6'b101001:            x = 5'd5;
      6'b011001:            x = 5'd6;
      6'b111000, 6'b000111: x = 5'd7;
      6'b111001, 6'b000110: x = 5'd8;
      6'b100101:            x = 5'd9;
      6'b010101:            x = 5'd10;
      6'b110100:            x = 5'd11;
      6'b001101:            x = 5'd12;
      6'b101100:            x = 5'd13;
      6'b011100:            x = 5'd14;
      6'b010111, 6'b101000: x = 5'd15;
      6'b011011, 6'b100100: x = 5'd16;
      6'b100011:            x = 5'd17;
      6'b010011:            x = 5'd18;
      6'b110010:            x = 5'd19;
      6'b001011:            x = 5'd20;
      6'b101010:            x = 5'd21;
      6'b011010:            x = 5'd22;
      6'b111010, 6'b000101: x = 5'd23;
      6'b110011, 6'b001100: x = 5'd24;
      6'b100110:            x = 5'd25;
      6'b010110:            x = 5'd26;
      6'b110110, 6'b001001: x = 5'd27;
      6'b001110:            x = 5'd28;
      6'b101110, 6'b010001: x = 5'd29;
      6'b011110, 6'b100001: x = 5'd30;
      6'b101011, 6'b010100: x = 5'd31;
      6'b001111, 6'b110000: x = 5'd28;
      default: begin
        x       = 5'd0;
        six_err = 1'b1;
      end
    endcase
  end

  always_comb begin
    four_err = 1'b0;
    case (four_adj)
      4'b1011, 4'b0100:                   y = 3'd0;
      4'b1001:                            y = 3'd1;
      4'b0101:                            y = 3'd2;
      4'b1100, 4'b0011:                   y = 3'd3;
      4'b1101, 4'b0010:                   y = 3'd4;
      4'b1010:                            y = 3'd5;
      4'b0110:                            y = 3'd6;
      4'b1110, 4'b0001, 4'b0111, 4'b1000: y = 3'd7;
      default: begin
        y        = 3'd0;
        four_err = 1'b1;
      end
    endcase
  end

  // Kx.7 uses the alternate 7 form, which data never pairs with these x.
  assign kx7 = !six_err && (four == 4'b0111 || four == 4'b1000) &&
               (x == 5'd23 || x == 5'd27 || x == 5'd29 || x == 5'd30);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sym_valid <= 1'b0;
    end else begin
      sym_valid <= code_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (code_valid) begin
      sym.data <= {y, x};
      sym.k    <= k28 || kx7;
      sym.err  <= six_err || four_err;
    end
  end

endmodule

/* comma_align.sv */
`timescale 1ns/1ns
`include "rx_macros.svh"

module comma_align (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          serial_in,
  output rx_pkg::code_t code,
  output logic          code_valid
);

  localparam logic [3:0] COMMA_LAST = 4'(`RX_COMMA_COUNT - 1);
  localparam logic [3:0] DATA_LAST  = 4'(`RX_FRAME_SYMBOLS - 1);

  rx_pkg::align_state_t state;
  rx_pkg::code_t        win;
  rx_pkg::code_t        win_next;
  logic [3:0]           bit_cnt;
  logic [3:0]           sym_cnt;
  logic                 is_comma;
  logic                 boundary;

  // Window as it stands once the bit of this cycle is shifted in.
  assign win_next = {win[8:0], serial_in};

  assign is_comma = (win_next == rx_pkg::K28_5_NEG) || (win_next == rx_pkg::K28_5_POS);

  // Tenth bit since the last framed symbol.
  assign boundary = (bit_cnt == 4'd9);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win <= '0;
    end else begin
      win <= win_next;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= rx_pkg::ALIGN_HUNT;
      bit_cnt    <= 4'd0;
      sym_cnt    <= 4'd0;
      code_valid <= 1'b0;
    end else begin
      code_valid <= 1'b0;
      bit_cnt    <= boundary ? 4'd0 : bit_cnt + 4'd1;
      case (state)
        rx_pkg::ALIGN_HUNT: begin
          // Any comma sets the symbol phase.
          if (is_comma) begin
            bit_cnt <= 4'd0;
            sym_cnt <= 4'd0;
            if (COMMA_LAST == 4'd0) begin
              state <= rx_pkg::ALIGN_DATA;
            end else begin
              state <= rx_pkg::ALIGN_COMMA;
            end
          end
        end
        rx_pkg::ALIGN_COMMA: begin
          if (boundary) begin
            if (!is_comma) begin
              state <= rx_pkg::ALIGN_HUNT;
            end else if (sym_cnt + 4'd1 == COMMA_LAST) begin
              sym_cnt <= 4'd0;
              state   <= rx_pkg::ALIGN_DATA;
            end else begin
              sym_cnt <= sym_cnt + 4'd1;
            end
          end
        end
        rx_pkg::ALIGN_DATA: begin
          if (boundary) begin
            code_valid <= 1'b1;
            if (sym_cnt == DATA_LAST) begin
              sym_cnt <= 4'd0;
              state   <= rx_pkg::ALIGN_HUNT;
            end else begin
              sym_cnt <= sym_cnt + 4'd1;
            end
          end
        end
        default: state <= rx_pkg::ALIGN_HUNT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == rx_pkg::ALIGN_DATA && boundary) begin
      code <= win_next;
    end
  end

endmodule

/* rx_pkg.sv */
package rx_pkg;

  // Ten-bit line code, first transmitted bit in bit 9.
  typedef logic [9:0] code_t;

  // K28.5 in both running disparities.
  localparam code_t K28_5_NEG = 10'h0FA;
  localparam code_t K28_5_POS = 10'h305;

  // Decoded symbol.
  typedef struct packed {
    logic [7:0] data;
    logic       k;
    logic       err;
  } sym_t;

  // Framing states of one lane.
  typedef enum logic [1:0] {
    ALIGN_HUNT  = 2'd0,
    ALIGN_COMMA = 2'd1,
    ALIGN_DATA  = 2'd2
  } align_state_t;

endpackage

/* rx_macros.svh */
`ifndef RX_MACROS_SVH
`define RX_MACROS_SVH

// Number of serial lanes merged into one word.
`define RX_LANES 4

// Back-to-back commas needed before a lane locks. Valid from 1 to 4.
`define RX_COMMA_COUNT 2

// Data symbols handed out per locked frame.
`define RX_FRAME_SYMBOLS 4

// Entries in each lane queue of the merge stage. Must be a power of two.
`define RX_QUEUE_DEPTH 4

`endif
